//--- Makefile
SIM  := obj_dir/Vdiv_exec_unit_tb
SRCS := filelist.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module div_exec_unit_tb -f filelist.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+rtl
rtl/pipe_pkg.sv
rtl/div_pkg.sv
rtl/leading_one_finder.sv
rtl/divider.sv
rtl/div_issue_ctrl.sv
rtl/div_exec_unit.sv
tests/div_exec_unit_properties.sv
tests/div_exec_unit_tb.sv

//--- rtl/div_exec_unit.sv
`timescale 1ns/10ps
`include "div_macros.svh"

module div_exec_unit
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  pipe_pkg::unit_type_e  id_type,
    input  logic [4:0]            id_subtype,
    input  logic [`DIV_WIDTH-1:0] id_din1,
    input  logic [`DIV_WIDTH-1:0] id_din2,
    input  pipe_pkg::reg_idx_t    id_dest,
    input  logic                  ex_flush,
    input  logic                  wb_stall,
    output logic                  id_stall,
    output logic                  wb_valid,
    output pipe_pkg::reg_idx_t    wb_dest,
    output logic [`DIV_WIDTH-1:0] wb_data
);

    import div_pkg::*;

    logic                  div_start;
    div_op_e               div_op;
    logic [`DIV_WIDTH-1:0] div_din1;
    logic [`DIV_WIDTH-1:0] div_din2;
    logic                  div_busy;
    logic                  div_done;
    logic [`DIV_WIDTH-1:0] div_result;
    logic [`DIV_WIDTH-1:0] rem_word;
    logic [`DIV_WIDTH-1:0] dsr_word;
    logic [4:0]            rem_msb;
    logic [4:0]            dsr_msb;

    div_issue_ctrl issue_i
    (
        .clk        (clk),
        .rst        (rst),
        .id_valid   (id_valid),
        .id_type    (id_type),
        .id_subtype (id_subtype),
        .id_din1    (id_din1),
        .id_din2    (id_din2),
        .id_dest    (id_dest),
        .ex_flush   (ex_flush),
        .wb_stall   (wb_stall),
        .div_busy   (div_busy),
        .div_done   (div_done),
        .div_result (div_result),
        .id_stall   (id_stall),
        .div_start  (div_start),
        .div_op     (div_op),
        .div_din1   (div_din1),
        .div_din2   (div_din2),
        .wb_valid   (wb_valid),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data)
    );

    divider div_i
    (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .flush    (ex_flush),
        .hold     (wb_stall),
        .op       (div_op),
        .din1     (div_din1),
        .din2     (div_din2),
        .rem_msb  (rem_msb),
        .dsr_msb  (dsr_msb),
        .rem_word (rem_word),
        .dsr_word (dsr_word),
        .busy     (div_busy),
        .done     (div_done),
        .dout     (div_result)
    );

    leading_one_finder rem_lof_i
    (
        .din (rem_word),
        .n   (rem_msb)
    );

    leading_one_finder dsr_lof_i
    (
        .din (dsr_word),
        .n   (dsr_msb)
    );

endmodule

//--- rtl/div_issue_ctrl.sv
`timescale 1ns/10ps
`include "div_macros.svh"

module div_issue_ctrl
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  pipe_pkg::unit_type_e  id_type,
    input  logic [4:0]            id_subtype,
    input  logic [`DIV_WIDTH-1:0] id_din1,
    input  logic [`DIV_WIDTH-1:0] id_din2,
    input  pipe_pkg::reg_idx_t    id_dest,
    input  logic                  ex_flush,
    input  logic                  wb_stall,
    input  logic                  div_busy,
    input  logic                  div_done,
    input  logic [`DIV_WIDTH-1:0] div_result,
    output logic                  id_stall,
    output logic                  div_start,
    output div_pkg::div_op_e      div_op,
    output logic [`DIV_WIDTH-1:0] div_din1,
    output logic [`DIV_WIDTH-1:0] div_din2,
    output logic                  wb_valid,
    output pipe_pkg::reg_idx_t    wb_dest,
    output logic [`DIV_WIDTH-1:0] wb_data
);

    import pipe_pkg::*;
    import div_pkg::*;

    logic       idex_valid;
    unit_type_e idex_type;
    reg_idx_t   idex_dest;
    reg_idx_t   run_dest;   // Destination of the running division.
    logic       accept;

    // Same condition the divider uses to leave IDLE.
    assign div_start = idex_valid && (idex_type == UNIT_DIV);
    assign accept    = div_start && !div_busy && !wb_stall && !ex_flush;
    assign id_stall  = div_start && !accept;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idex_valid <= 1'b0;
            wb_valid   <= 1'b0;
        end
        else
        begin
            if (ex_flush)
                idex_valid <= 1'b0;
            else if (!id_stall)
                idex_valid <= id_valid;  // Other unit types drop out next cycle.
            wb_valid <= div_done && !ex_flush;
        end
    end

    always_ff @(posedge clk)
    begin
        if (id_valid && !id_stall)
        begin
            idex_type <= id_type;
            div_op    <= div_op_e'(id_subtype);
            div_din1  <= id_din1;
            div_din2  <= id_din2;
            idex_dest <= id_dest;
        end
        if (accept)
            run_dest <= idex_dest;
        if (div_done)
        begin
            wb_dest <= run_dest;
            wb_data <= div_result;
        end
    end

endmodule

//--- rtl/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// ====================
// Divider datapath sizes
// ====================

`define DIV_WIDTH 32
`define DIV_CNT_W 6
`define REG_IDX_W 5

`endif

//--- rtl/div_pkg.sv
package div_pkg;

    typedef enum logic [4:0]
    {
        DIVW  = 5'd0,  // Signed quotient.
        MODW  = 5'd1,  // Signed remainder.
        DIVWU = 5'd2,  // Unsigned quotient.
        MODWU = 5'd3   // Unsigned remainder.
    } div_op_e;

    typedef enum logic [2:0]
    {
        IDLE    = 3'd0,
        LOAD    = 3'd1,
        ALIGN   = 3'd2,
        ITERATE = 3'd3,
        FINISH  = 3'd4
    } div_state_e;

    function automatic logic op_is_signed(input div_op_e op);
        return (op == DIVW) || (op == MODW);
    endfunction

    function automatic logic op_is_rem(input div_op_e op);
        return (op == MODW) || (op == MODWU);
    endfunction

endpackage

//--- rtl/divider.sv
`timescale 1ns/10ps
`include "div_macros.svh"

module divider
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  flush,
    input  logic                  hold,
    input  div_pkg::div_op_e      op,
    input  logic [`DIV_WIDTH-1:0] din1,
    input  logic [`DIV_WIDTH-1:0] din2,
    input  logic [4:0]            rem_msb,
    input  logic [4:0]            dsr_msb,
    output logic [`DIV_WIDTH-1:0] rem_word,
    output logic [`DIV_WIDTH-1:0] dsr_word,
    output logic                  busy,
    output logic                  done,
    output logic [`DIV_WIDTH-1:0] dout
);

    import div_pkg::*;

    localparam int MSB = `DIV_WIDTH - 1;

    div_state_e            state;
    div_op_e               op_q;
    logic [`DIV_WIDTH-1:0] dvd_q;    // Dividend as issued.
    logic [`DIV_WIDTH-1:0] dvs_q;    // Divisor as issued.
    logic [`DIV_WIDTH-1:0] rem;      // Working remainder magnitude.
    logic [`DIV_WIDTH-1:0] dsr;      // Divisor magnitude.
    logic [`DIV_WIDTH-1:0] quo;
    logic [`DIV_CNT_W-1:0] cnt;      // Signed remaining shift.
    logic                  neg_quo;
    logic                  neg_rem;

    logic                  sgn;
    logic [`DIV_CNT_W-1:0] align_cnt;
    logic [`DIV_WIDTH:0]   trial;
    logic [`DIV_WIDTH-1:0] quo_out;
    logic [`DIV_WIDTH-1:0] rem_out;

    assign busy     = (state != IDLE);
    assign rem_word = rem;
    assign dsr_word = dsr;
    assign sgn      = op_is_signed(op_q);

    // Negative when the remainder's top bit sits below the divisor's.
    assign align_cnt = {1'b0, rem_msb} - {1'b0, dsr_msb};

    // One restoring step against the divisor shifted by the current count.
    assign trial = {1'b0, rem} - ({1'b0, dsr} << cnt[4:0]);

    assign quo_out = neg_quo ? (`DIV_WIDTH'(0) - quo) : quo;
    assign rem_out = neg_rem ? (`DIV_WIDTH'(0) - rem) : rem;

    // ====================
    // Control
    // ====================

    always_ff @(posedge clk)
    begin
        done <= 1'b0;
        if (rst || flush)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start && !hold)
                        state <= LOAD;
                end
                LOAD:
                begin
                    if (dvs_q == '0)
                        state <= FINISH;  // Divide by zero needs no steps.
                    else
                        state <= ALIGN;
                end
                ALIGN:
                begin
                    if (align_cnt[`DIV_CNT_W-1] || (rem < dsr))
                        state <= FINISH;  // Quotient is zero.
                    else
                        state <= ITERATE;
                end
                ITERATE:
                begin
                    if (cnt == '0)
                        state <= FINISH;
                end
                FINISH:
                begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ====================
    // Datapath
    // ====================

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                if (start)
                begin
                    op_q  <= op;
                    dvd_q <= din1;
                    dvs_q <= din2;
                end
            end
            LOAD:
            begin
                quo <= '0;
                dsr <= (sgn && dvs_q[MSB]) ? (`DIV_WIDTH'(0) - dvs_q) : dvs_q;
                if (dvs_q == '0)
                begin
                    quo     <= '1;
                    rem     <= dvd_q;
                    neg_quo <= 1'b0;
                    neg_rem <= 1'b0;
                end
                else
                begin
                    rem     <= (sgn && dvd_q[MSB]) ? (`DIV_WIDTH'(0) - dvd_q) : dvd_q;
                    neg_quo <= sgn && (dvd_q[MSB] ^ dvs_q[MSB]);
                    neg_rem <= sgn && dvd_q[MSB];  // Remainder follows the dividend.
                end
            end
            ALIGN:
            begin
                cnt <= align_cnt;
            end
            ITERATE:
            begin
                cnt <= cnt - `DIV_CNT_W'(1);
                quo <= {quo[MSB-1:0], ~trial[`DIV_WIDTH]};
                if (!trial[`DIV_WIDTH])
                    rem <= trial[MSB:0];
            end
            FINISH:
            begin
                if (op_is_rem(op_q))
                    dout <= rem_out;
                else
                    dout <= quo_out;
            end
            default:
            begin
            end
        endcase
    end

endmodule

//--- rtl/leading_one_finder.sv
`timescale 1ns/10ps
`include "div_macros.svh"

module leading_one_finder
(
    input  logic [`DIV_WIDTH-1:0] din,
    output logic [4:0]            n
);

    logic [15:0] win16;
    logic [7:0]  win8;
    logic [3:0]  win4;
    logic [1:0]  win2;

    // Each step keeps the upper half when it holds a one.
    always_comb
    begin
        n[4] = |din[31:16];
        if (n[4])
            win16 = din[31:16];
        else
            win16 = din[15:0];

        n[3] = |win16[15:8];
        if (n[3])
            win8 = win16[15:8];
        else
            win8 = win16[7:0];

        n[2] = |win8[7:4];
        if (n[2])
            win4 = win8[7:4];
        else
            win4 = win8[3:0];

        n[1] = |win4[3:2];
        if (n[1])
            win2 = win4[3:2];
        else
            win2 = win4[1:0];

        n[0] = win2[1];  // Zero input falls through to 0.
    end

endmodule

//--- rtl/pipe_pkg.sv
`include "div_macros.svh"

package pipe_pkg;

    // ====================
    // Issue routing
    // ====================

    typedef enum logic [3:0]
    {
        UNIT_ALU = 4'd0,  // Integer ALU.
        UNIT_MUL = 4'd1,  // Multiplier.
        UNIT_DIV = 4'd2,  // The only unit taken by this slice.
        UNIT_LSU = 4'd3   // Load/store.
    } unit_type_e;

    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

endpackage

//--- tests/div_exec_unit_properties.sv
`timescale 1ns/10ps
`include "div_macros.svh"

module div_exec_unit_properties
(
    input logic                  clk,
    input logic                  rst,
    input logic                  id_valid,
    input pipe_pkg::unit_type_e  id_type,
    input logic [4:0]            id_subtype,
    input logic [`DIV_WIDTH-1:0] id_din1,
    input logic [`DIV_WIDTH-1:0] id_din2,
    input pipe_pkg::reg_idx_t    id_dest,
    input logic                  ex_flush,
    input logic                  wb_stall,
    input logic                  div_busy,
    input logic                  id_stall,
    input logic                  wb_valid,
    input pipe_pkg::reg_idx_t    wb_dest,
    input logic [`DIV_WIDTH-1:0] wb_data
);

    import pipe_pkg::*;
    import div_pkg::*;

    localparam logic [`DIV_WIDTH-1:0] MIN_INT = {1'b1, {(`DIV_WIDTH-1){1'b0}}};

    logic [`DIV_WIDTH-1:0] exp_data_q[$];  // Accepted, unflushed divide ops in order.
    reg_idx_t              exp_dest_q[$];
    logic                  head_valid;
    logic [`DIV_WIDTH-1:0] head_data;
    reg_idx_t              head_dest;
    logic                  held;           // A divide op waits in ID/EX.
    int                    fail_count = 0;

    function automatic logic [`DIV_WIDTH-1:0] model_result(input logic [4:0] sub,
        input logic [`DIV_WIDTH-1:0] a, input logic [`DIV_WIDTH-1:0] b);
        logic                         is_signed;
        logic                         want_rem;
        logic signed [`DIV_WIDTH-1:0] sa;
        logic signed [`DIV_WIDTH-1:0] sb;
        is_signed = (sub == DIVW) || (sub == MODW);
        want_rem = (sub == MODW) || (sub == MODWU);
        sa = a;
        sb = b;
        if (b == '0)
            return want_rem ? a : {`DIV_WIDTH{1'b1}};
        if (is_signed && (a == MIN_INT) && (sb == -1))
            return want_rem ? '0 : MIN_INT;
        if (is_signed)
            return want_rem ? (sa % sb) : (sa / sb);  // Truncates toward zero.
        return want_rem ? (a % b) : (a / b);
    endfunction

    // ====================
    // Reference model
    // ====================

    always @(posedge clk)
    begin
        if (rst)
        begin
            exp_data_q.delete();
            exp_dest_q.delete();
            held <= 1'b0;
        end
        else
        begin
            if (wb_valid && (exp_data_q.size() > 0))
            begin
                void'(exp_data_q.pop_front());
                void'(exp_dest_q.pop_front());
            end
            if (ex_flush)
            begin
                exp_data_q.delete();  // Kills the running and the held op.
                exp_dest_q.delete();
                held <= 1'b0;
            end
            else if (id_valid && !id_stall && (id_type == UNIT_DIV))
            begin
                exp_data_q.push_back(model_result(id_subtype, id_din1, id_din2));
                exp_dest_q.push_back(id_dest);
                held <= 1'b1;
            end
            else if (!id_stall)
                held <= 1'b0;
        end
        if (exp_data_q.size() > 0)
        begin
            head_valid <= 1'b1;
            head_data  <= exp_data_q[0];
            head_dest  <= exp_dest_q[0];
        end
        else
            head_valid <= 1'b0;
    end

    // ====================
    // Checks
    // ====================

    a_reset_quiet: assert property (@(posedge clk) rst |=> !id_stall && !wb_valid)
        else
        begin
            $error("Stall or writeback active right after reset");
            fail_count++;
        end

    a_stall_needs_op: assert property (@(posedge clk) disable iff (rst)
        !held |-> !id_stall)
        else
        begin
            $error("Decode stalled with no divide op waiting in ID/EX");
            fail_count++;
        end

    a_stall_when_blocked: assert property (@(posedge clk) disable iff (rst)
        held && (div_busy || wb_stall) |-> id_stall)
        else
        begin
            $error("Decode not stalled while the waiting op cannot start");
            fail_count++;
        end

    a_wb_expected: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> head_valid)
        else
        begin
            $error("Writeback with no operation outstanding");
            fail_count++;
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        wb_valid && head_valid |-> wb_data == head_data)
        else
        begin
            $error("Fail wb_data got %h expected %h", $sampled(wb_data), $sampled(head_data));
            fail_count++;
        end

    a_wb_dest: assert property (@(posedge clk) disable iff (rst)
        wb_valid && head_valid |-> wb_dest == head_dest)
        else
        begin
            $error("Fail wb_dest got %h expected %h", $sampled(wb_dest), $sampled(head_dest));
            fail_count++;
        end

endmodule

bind div_exec_unit div_exec_unit_properties props_i (.*);

//--- tests/div_exec_unit_tb.sv
`timescale 1ns/10ps
`include "div_macros.svh"

module div_exec_unit_tb;

    import pipe_pkg::*;
    import div_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  rst;
    logic                  id_valid;
    unit_type_e            id_type;
    logic [4:0]            id_subtype;
    logic [`DIV_WIDTH-1:0] id_din1;
    logic [`DIV_WIDTH-1:0] id_din2;
    reg_idx_t              id_dest;
    logic                  ex_flush;
    logic                  wb_stall;
    logic                  id_stall;
    logic                  wb_valid;
    reg_idx_t              wb_dest;
    logic [`DIV_WIDTH-1:0] wb_data;

    int                    seed;
    int                    timeout_count;
    int                    fails;
    int                    want_wb;
    int                    wb_count = 0;
    int                    shift;
    logic                  stall_at_edge;
    logic [`DIV_WIDTH-1:0] a;
    logic [`DIV_WIDTH-1:0] b;

    div_exec_unit dut_i
    (
        .clk        (clk),
        .rst        (rst),
        .id_valid   (id_valid),
        .id_type    (id_type),
        .id_subtype (id_subtype),
        .id_din1    (id_din1),
        .id_din2    (id_din2),
        .id_dest    (id_dest),
        .ex_flush   (ex_flush),
        .wb_stall   (wb_stall),
        .id_stall   (id_stall),
        .wb_valid   (wb_valid),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        stall_at_edge <= id_stall;  // Low here means decode was taken.
        if (!rst && wb_valid)
            wb_count <= wb_count + 1;
    end

    // ====================
    // Stimulus tasks
    // ====================

    task automatic issue_op(input unit_type_e ty, input div_op_e op,
        input logic [`DIV_WIDTH-1:0] x, input logic [`DIV_WIDTH-1:0] y, input reg_idx_t dest);
        int waited;
        waited = 0;
        id_valid   = 1'b1;
        id_type    = ty;
        id_subtype = op;
        id_din1    = x;
        id_din2    = y;
        id_dest    = dest;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (stall_at_edge && (waited < WAIT_LIMIT));
        if (stall_at_edge)
        begin
            $display("Timeout: operation was never taken into ID/EX");
            timeout_count++;
        end
        id_valid = 1'b0;
    endtask

    task automatic issue_div(input div_op_e op, input logic [`DIV_WIDTH-1:0] x,
        input logic [`DIV_WIDTH-1:0] y, input reg_idx_t dest);
        issue_op(UNIT_DIV, op, x, y, dest);
        want_wb++;
    endtask

    task automatic wait_writebacks(input int target);
        int waited;
        waited = 0;
        while ((wb_count < target) && (waited < WAIT_LIMIT))
        begin
            @(negedge clk);
            waited++;
        end
        if (wb_count < target)
        begin
            $display("Timeout: only %0d of %0d writebacks arrived", wb_count, target);
            timeout_count++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic flush_pulse();
        ex_flush = 1'b1;
        @(negedge clk);
        ex_flush = 1'b0;
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        seed = 92;
        timeout_count = 0;
        want_wb = 0;
        clk = 1'b0;
        rst = 1'b1;
        id_valid = 1'b0;
        id_type = UNIT_ALU;
        id_subtype = '0;
        id_din1 = '0;
        id_din2 = '0;
        id_dest = '0;
        ex_flush = 1'b0;
        wb_stall = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_cycles(4);

        for (int i = 0; i < 12; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            shift = $unsigned($random(seed)) % 32;
            b = b >> shift;
            issue_div((i % 2 == 0) ? DIVWU : MODWU, a, b, reg_idx_t'(i + 1));
            wait_writebacks(want_wb);
        end

        for (int k = 0; k < 4; k++)
        begin
            a = k[0] ? (32'd0 - 32'd1000) : 32'd1000;
            b = k[1] ? (32'd0 - 32'd7) : 32'd7;
            issue_div(DIVW, a, b, reg_idx_t'(10 + k));
            issue_div(MODW, a, b, reg_idx_t'(20 + k));
            wait_writebacks(want_wb);
        end
        for (int i = 0; i < 6; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            b = $signed(b) >>> ($unsigned($random(seed)) % 28);
            issue_div((i % 2 == 0) ? DIVW : MODW, a, b, reg_idx_t'(i + 24));
            wait_writebacks(want_wb);
        end

        issue_div(DIVW, 32'h1234_5678, 32'd0, 5'd1);
        issue_div(MODW, 32'h8765_4321, 32'd0, 5'd2);
        issue_div(DIVWU, 32'hDEAD_BEEF, 32'd0, 5'd3);
        issue_div(MODWU, 32'hDEAD_BEEF, 32'd0, 5'd4);
        issue_div(DIVW, 32'h8000_0000, 32'hFFFF_FFFF, 5'd5);
        issue_div(MODW, 32'h8000_0000, 32'hFFFF_FFFF, 5'd6);
        issue_div(DIVWU, 32'd5, 32'd9, 5'd7);
        issue_div(DIVW, 32'd0 - 32'd5, 32'd9, 5'd8);
        issue_div(MODWU, 32'd5, 32'd9, 5'd9);
        wait_writebacks(want_wb);
        issue_op(UNIT_ALU, DIVW, 32'd1, 32'd1, 5'd30);  // Dropped as it goes to another unit.
        wait_cycles(4);

        // Three in flight with one running, one held and one stalled in decode.
        issue_div(DIVWU, 32'hFFFF_FFFF, 32'd1, 5'd12);
        issue_div(MODWU, 32'hFFFF_FFF0, 32'd3, 5'd13);
        issue_div(DIVW, 32'h7FFF_0000, 32'd0 - 32'd3, 5'd14);
        wait_writebacks(want_wb);
        wb_stall = 1'b1;
        issue_div(DIVWU, 32'd1000, 32'd10, 5'd15);
        wait_cycles(6);
        wb_stall = 1'b0;
        wait_writebacks(want_wb);
        issue_div(DIVWU, 32'hF000_0000, 32'd5, 5'd16);
        issue_div(MODWU, 32'h0F00_0000, 32'd7, 5'd17);
        wb_stall = 1'b1;
        wait_writebacks(want_wb - 1);
        wait_cycles(3);
        wb_stall = 1'b0;
        wait_writebacks(want_wb);

        issue_op(UNIT_DIV, DIVWU, 32'hFFFF_FFFF, 32'd1, 5'd18);
        wait_cycles(6);
        flush_pulse();
        issue_div(DIVWU, 32'd100, 32'd7, 5'd19);
        wait_writebacks(want_wb);
        issue_op(UNIT_DIV, DIVWU, 32'hFFFF_FFFF, 32'd1, 5'd20);
        issue_op(UNIT_DIV, MODWU, 32'd77, 32'd5, 5'd21);
        flush_pulse();
        wb_stall = 1'b1;
        issue_op(UNIT_DIV, DIVW, 32'd50, 32'd3, 5'd22);
        flush_pulse();
        wb_stall = 1'b0;
        issue_div(MODW, 32'd0 - 32'd100, 32'd7, 5'd23);
        wait_writebacks(want_wb);
        wait_cycles(6);

        fails = dut_i.props_i.fail_count;
        $display("Assertion failures: %0d, timeouts: %0d", fails, timeout_count);
        if ((fails + timeout_count) == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
